/* src/nn_macros.svh */
`ifndef NN_MACROS_SVH
`define NN_MACROS_SVH

// pixel stream
`define PIXEL_W 8                        // raw unsigned pixel
`define INPUT_LEN 16                     // pixels per image

// fixed point
`define Q_W 16                           // Q15 weights and activations
`define ACC_W 32                         // MAC accumulator

// layer geometry
`define NUM_NEURONS 4                    // same count in both layers

// row address covers the deeper of the two weight memories
`define ROW_ADDR_W ($clog2((`INPUT_LEN > `NUM_NEURONS) ? `INPUT_LEN : `NUM_NEURONS))

// one weight row, neuron 0 in the low bits
`define ROW_W (`NUM_NEURONS * `Q_W)

`endif

/* src/nn_pkg.sv */
`include "nn_macros.svh"

package nn_pkg;

  // signed Q15 word, 1 sign bit + 15 fraction bits
  typedef logic signed [`Q_W-1:0] q15_t;

  // wide accumulator, holds Q30 sums
  typedef logic signed [`ACC_W-1:0] acc_t;

  // which weight memory / operand source is in use
  typedef enum logic {
    layer_hidden,                        // pixel x hidden weights
    layer_output                         // hidden act x output weights
  } layer_sel_t;

  // sequencing FSM states
  typedef enum logic [2:0] {
    st_load,                             // take pixels, one MAC each
    st_hidden_capture,                   // latch hidden act, clear acc
    st_output_mac,                       // one MAC per hidden neuron
    st_output_capture,                   // latch result, clear acc
    st_result                            // hold result until taken
  } ctrl_state_t;

endpackage

/* src/weight_mem.sv */
`timescale 1ns/1ps
`include "nn_macros.svh"

module weight_mem #(
  parameter int                 DEPTH     = `INPUT_LEN,
  parameter nn_pkg::layer_sel_t MEM_LAYER = nn_pkg::layer_hidden
) (
  input  logic                   clk,
  input  logic                   w_we,
  input  nn_pkg::layer_sel_t     w_layer,
  input  logic [`ROW_ADDR_W-1:0] w_addr,
  input  logic [`ROW_W-1:0]      w_data,
  input  logic [`ROW_ADDR_W-1:0] row_addr,
  output logic [`ROW_W-1:0]      row
);

  localparam int AW = $clog2(DEPTH);     // local index width

  logic [`ROW_W-1:0] mem [DEPTH];        // one row per input / neuron
  logic              wr_hit;             // write aimed at this layer

  // shared write bus, only our layer and in-range rows land here
  assign wr_hit = w_we && (w_layer == MEM_LAYER) && (w_addr < DEPTH);

  always_ff @(posedge clk) begin
    if (wr_hit) begin
      mem[w_addr[AW-1:0]] <= w_data;
    end
  end

  // async lookup, row is valid in the same cycle as row_addr
  // upper address bits ignored for the shallow output memory
  assign row = mem[row_addr[AW-1:0]];

endmodule

/* src/mac_slice.sv */
`timescale 1ns/1ps
`include "nn_macros.svh"

module mac_slice (
  input  logic         clk,
  input  logic         reset,
  input  logic         mac_en,
  input  logic         clear,
  input  nn_pkg::q15_t a,                // shared operand
  input  nn_pkg::q15_t w,                // this neuron's weight
  output nn_pkg::q15_t act
);

  import nn_pkg::*;

  acc_t prod;                            // raw Q30 product
  acc_t acc_q;                           // running sum

  // sign-extend first so the product is a full 32 bit signed value
  assign prod = acc_t'(a) * acc_t'(w);

  // Q15 x Q15 gives Q30, shift left one to line up with the acc
  // overflow simply wraps, matches the reference arithmetic
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      acc_q <= '0;
    end else if (clear) begin
      acc_q <= '0;                       // start of next layer
    end else if (mac_en) begin
      acc_q <= acc_q + (prod <<< 1);
    end
  end

  // relu + saturating rescale back to Q15
  always_comb begin
    if (acc_q[`ACC_W-1]) begin
      act = '0;                          // negative clamps to zero
    end else if (acc_q[`ACC_W-2]) begin
      act = {1'b0, {(`Q_W-1){1'b1}}};    // >= 2^30, saturate 0x7fff
    end else begin
      act = acc_q[`ACC_W-2 -: `Q_W];     // bits 30:15
    end
  end

endmodule

/* src/neuron_array.sv */
`timescale 1ns/1ps
`include "nn_macros.svh"

module neuron_array (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`PIXEL_W-1:0]    pixel,
  input  logic                   mac_en,
  input  nn_pkg::layer_sel_t     src_sel,
  input  logic                   hidden_capture,
  input  logic                   result_capture,
  input  logic [`ROW_ADDR_W-1:0] row_addr,
  input  logic [`ROW_W-1:0]      hidden_row,
  input  logic [`ROW_W-1:0]      output_row,
  output logic [`ROW_W-1:0]      result
);

  import nn_pkg::*;

  localparam int NIDX_W = $clog2(`NUM_NEURONS); // hidden bank index width

  q15_t              pixel_q15;          // pixel as a positive Q15 value
  q15_t              operand;            // broadcast to every slice
  q15_t              hidden_act [`NUM_NEURONS]; // stored hidden layer
  q15_t              slice_act [`NUM_NEURONS];  // live slice outputs
  logic [`ROW_W-1:0] sel_row;            // weight row for this MAC
  logic              slice_clear;

  // p -> p * 128, i.e. 0.pppppppp in Q15
  assign pixel_q15 = {1'b0, pixel, {(`Q_W-`PIXEL_W-1){1'b0}}};

  // hidden phase uses the pixel, output phase walks the hidden bank
  assign operand = (src_sel == layer_hidden) ? pixel_q15
                                             : hidden_act[row_addr[NIDX_W-1:0]];
  assign sel_row = (src_sel == layer_hidden) ? hidden_row : output_row;

  // accumulators restart after every capture
  assign slice_clear = hidden_capture | result_capture;

  generate
    for (genvar n = 0; n < `NUM_NEURONS; n++) begin : g_slice
      mac_slice u_mac_slice (
        .clk    (clk),
        .reset  (reset),
        .mac_en (mac_en),
        .clear  (slice_clear),
        .a      (operand),
        .w      (sel_row[n*`Q_W +: `Q_W]), // neuron n weight
        .act    (slice_act[n])
      );
    end
  endgenerate

  // hidden activation bank, loaded once per image
  always_ff @(posedge clk) begin
    if (hidden_capture) begin
      hidden_act <= slice_act;
    end
  end

  // result register, held steady while the consumer stalls
  always_ff @(posedge clk) begin
    if (result_capture) begin
      for (int n = 0; n < `NUM_NEURONS; n++) begin
        result[n*`Q_W +: `Q_W] <= slice_act[n];   // neuron 0 lowest
      end
    end
  end

endmodule

/* src/layer_controller.sv */
`timescale 1ns/1ps
`include "nn_macros.svh"

module layer_controller (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   pixel_valid,
  output logic                   pixel_ready,
  output logic                   result_valid,
  input  logic                   result_ready,
  output logic                   mac_en,
  output logic                   hidden_capture,
  output logic                   result_capture,
  output nn_pkg::layer_sel_t     src_sel,
  output logic [`ROW_ADDR_W-1:0] row_addr
);

  import nn_pkg::*;

  localparam int AW = `ROW_ADDR_W;
  localparam logic [AW-1:0] last_pixel_row  = AW'(`INPUT_LEN - 1);
  localparam logic [AW-1:0] last_neuron_row = AW'(`NUM_NEURONS - 1);

  ctrl_state_t   state;
  ctrl_state_t   state_next;
  logic [AW-1:0] row_next;
  logic          started;                // low for the first edge after reset
  logic          accept;                 // pixel handshake

  // hold off pixel_ready for one cycle out of reset
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      started <= 1'b0;
    end else begin
      started <= 1'b1;
    end
  end

  assign pixel_ready    = (state == st_load) && started;
  assign accept         = pixel_valid && pixel_ready;
  assign result_valid   = (state == st_result);
  assign hidden_capture = (state == st_hidden_capture);
  assign result_capture = (state == st_output_capture);
  assign mac_en         = accept || (state == st_output_mac);
  assign src_sel        = (state == st_load) ? layer_hidden : layer_output;

  always_comb begin
    state_next = state;
    row_next   = row_addr;
    case (state)
      st_load: begin
        if (accept) begin
          if (row_addr == last_pixel_row) begin
            state_next = st_hidden_capture;   // last pixel taken
            row_next   = '0;
          end else begin
            row_next = row_addr + 1'b1;
          end
        end
      end
      st_hidden_capture: state_next = st_output_mac;
      st_output_mac: begin
        if (row_addr == last_neuron_row) begin
          state_next = st_output_capture;
          row_next   = '0;
        end else begin
          row_next = row_addr + 1'b1;         // next hidden act
        end
      end
      st_output_capture: state_next = st_result;
      st_result: begin
        if (result_ready) begin
          state_next = st_load;               // hand-off done
        end
      end
      default: begin
        state_next = st_load;
        row_next   = '0;
      end
    endcase
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state    <= st_load;
      row_addr <= '0;
    end else begin
      state    <= state_next;
      row_addr <= row_next;
    end
  end

  // row index stays inside the weight rows read in each phase
  a_load_row_range: assert property (@(posedge clk) disable iff (reset)
    row_addr < ((state == st_load) ? `INPUT_LEN : `NUM_NEURONS))
    else $error("row_addr out of range for the current state");

  // result shows up NUM_NEURONS+2 edges after the last pixel edge
  a_result_latency: assert property (@(posedge clk) disable iff (reset)
    $rose(result_valid) |-> $past(accept && (row_addr == last_pixel_row), `NUM_NEURONS + 3))
    else $error("result_valid rose at the wrong distance from the last pixel");

  // result held until the consumer takes it
  a_result_hold: assert property (@(posedge clk) disable iff (reset)
    (result_valid && !result_ready) |=> result_valid)
    else $error("result_valid dropped without result_ready");

endmodule

/* src/nn_core.sv */
`timescale 1ns/1ps
`include "nn_macros.svh"

module nn_core (
  input  logic                   clk,
  input  logic                   reset,

  // pixel stream in
  input  logic                   pixel_valid,
  input  logic [`PIXEL_W-1:0]    pixel,
  output logic                   pixel_ready,

  // weight load port, one row per cycle
  input  logic                   w_we,
  input  nn_pkg::layer_sel_t     w_layer,
  input  logic [`ROW_ADDR_W-1:0] w_addr,
  input  logic [`ROW_W-1:0]      w_data,

  // activation vector out
  output logic                   result_valid,
  output logic [`ROW_W-1:0]      result,
  input  logic                   result_ready
);

  import nn_pkg::*;

  logic [`ROW_ADDR_W-1:0] row_addr;      // shared by both memories
  logic                   mac_en;
  logic                   hidden_capture;
  logic                   result_capture;
  layer_sel_t             src_sel;
  logic [`ROW_W-1:0]      hidden_row;
  logic [`ROW_W-1:0]      output_row;

  layer_controller u_layer_controller (
    .clk            (clk),
    .reset          (reset),
    .pixel_valid    (pixel_valid),
    .pixel_ready    (pixel_ready),
    .result_valid   (result_valid),
    .result_ready   (result_ready),
    .mac_en         (mac_en),
    .hidden_capture (hidden_capture),
    .result_capture (result_capture),
    .src_sel        (src_sel),
    .row_addr       (row_addr)
  );

  // one row per input pixel
  weight_mem #(.DEPTH(`INPUT_LEN), .MEM_LAYER(layer_hidden)) u_hidden_mem (
    .clk      (clk),
    .w_we     (w_we),
    .w_layer  (w_layer),
    .w_addr   (w_addr),
    .w_data   (w_data),
    .row_addr (row_addr),
    .row      (hidden_row)
  );

  // one row per hidden neuron
  weight_mem #(.DEPTH(`NUM_NEURONS), .MEM_LAYER(layer_output)) u_output_mem (
    .clk      (clk),
    .w_we     (w_we),
    .w_layer  (w_layer),
    .w_addr   (w_addr),
    .w_data   (w_data),
    .row_addr (row_addr),
    .row      (output_row)
  );

  neuron_array u_neuron_array (
    .clk            (clk),
    .reset          (reset),
    .pixel          (pixel),
    .mac_en         (mac_en),
    .src_sel        (src_sel),
    .hidden_capture (hidden_capture),
    .result_capture (result_capture),
    .row_addr       (row_addr),
    .hidden_row     (hidden_row),
    .output_row     (output_row),
    .result         (result)
  );

endmodule

/* tests/nn_ref_model.svh */
`ifndef NN_REF_MODEL_SVH
`define NN_REF_MODEL_SVH

typedef logic [`ROW_W-1:0] vec_t;        // one full result vector

// golden copies of what gets loaded into the dut
int pix_vals [`INPUT_LEN];
int hid_w [`INPUT_LEN][`NUM_NEURONS];    // [pixel][neuron]
int out_w [`NUM_NEURONS][`NUM_NEURONS];  // [hidden][output]

logic [15:0] lfsr_state = 16'd62197;

// fibonacci lfsr x^16+x^14+x^13+x^11+1, one step per bit
function automatic int lfsr_bits(input int n);
  int   v;
  logic fb;
  v = 0;
  for (int b = 0; b < n; b++) begin
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    v = (v << 1) | int'(fb);             // msb first
  end
  return v;
endfunction

// sign bit then 11 bit magnitude, never beyond 2047
function automatic int rand_weight();
  int neg;
  neg = lfsr_bits(1);
  return (neg != 0) ? -lfsr_bits(11) : lfsr_bits(11);
endfunction

// relu then saturate at 2^30, else drop 15 fraction bits
function automatic int ref_activation(input int acc);
  if (acc < 0) return 0;
  return (acc >= 32'sh4000_0000) ? 32767 : acc / 32768;
endfunction

// two layer forward pass, int math wraps like the 32 bit acc
function automatic vec_t ref_forward();
  int   acc;
  int   hid [`NUM_NEURONS];
  vec_t res;
  res = '0;
  for (int n = 0; n < `NUM_NEURONS; n++) begin
    acc = 0;
    for (int i = 0; i < `INPUT_LEN; i++) begin
      acc += pix_vals[i] * 128 * hid_w[i][n] * 2;  // pixel as p*128 in Q15
    end
    hid[n] = ref_activation(acc);
  end
  for (int n = 0; n < `NUM_NEURONS; n++) begin
    acc = 0;
    for (int k = 0; k < `NUM_NEURONS; k++) begin
      acc += hid[k] * out_w[k][n] * 2;
    end
    res[n*`Q_W +: `Q_W] = q15_t'(ref_activation(acc));  // neuron 0 lowest
  end
  return res;
endfunction

task automatic check(input vec_t actual, input vec_t want, input string what);
  if (actual !== want) begin
    $display("MISMATCH at %0t: %s (got %h, expected %h)", $time, what, actual, want);
    $display("Simulation failed");
    $fatal(1, "check failed: %s", what);
  end
endtask

`endif

/* tests/nn_core_tb.sv */
`timescale 1ns/1ps
`include "nn_macros.svh"

module nn_core_tb;

  import nn_pkg::*;

  logic                   clk;
  logic                   reset;
  logic                   pixel_valid;
  logic [`PIXEL_W-1:0]    pixel;
  logic                   pixel_ready;
  logic                   w_we;
  layer_sel_t             w_layer;
  logic [`ROW_ADDR_W-1:0] w_addr;
  logic [`ROW_W-1:0]      w_data;
  logic                   result_valid;
  logic [`ROW_W-1:0]      result;
  logic                   result_ready;

  `include "nn_ref_model.svh"

  typedef logic [`ROW_ADDR_W-1:0] addr_t;
  typedef logic [`PIXEL_W-1:0]    pix_t;

  localparam int wmode_random = 0;
  localparam int wmode_ident  = 1;       // 0x4000 diagonal, simple output mix
  localparam int wmode_sat    = 2;       // relu clamp and 0x7fff saturation
  localparam int pmode_random = 0;
  localparam int pmode_ramp   = 1;       // 16*i + 10
  localparam int pmode_full   = 2;       // every pixel 255

  typedef struct packed {
    int   wmode;
    int   pmode;
    int   gap;                           // pixel_valid gap chance in 16ths
    int   stall;                         // result_ready stall chance in 16ths
    vec_t expected;                      // hand computed, fixed rows only
  } test_row_t;

  localparam int num_tests = 7;
  localparam test_row_t tests [num_tests] = '{
    '{wmode_ident,  pmode_ramp,   0, 0,  64'h1f80_2380_1780_0b80},
    '{wmode_sat,    pmode_full,   0, 0,  64'h7fff_7f80_7fff_0000},
    '{wmode_random, pmode_random, 0, 0,  '0},
    '{wmode_random, pmode_random, 6, 0,  '0},
    '{wmode_random, pmode_random, 0, 8,  '0},
    '{wmode_random, pmode_random, 9, 10, '0},
    '{wmode_ident,  pmode_ramp,   5, 7,  64'h1f80_2380_1780_0b80}
  };

  // per image budget scales with the pixel stream
  localparam int watchdog_cycles = num_tests * (`INPUT_LEN * 4 + `NUM_NEURONS + 40);

  // only hidden row 0 is nonzero in the saturation case
  localparam int sat_hidden [`NUM_NEURONS] = '{-16384, 32767, 16384, 8192};
  localparam int sat_output [`NUM_NEURONS][`NUM_NEURONS] = '{
    '{0, 0, 0, 0},
    '{-16384, 32767, 0, 0},              // out0 negative, out1 above 2^30
    '{0, 0, 16384, 16384},
    '{0, 0, 0, 16384}                    // out3 sums past 2^30
  };

  vec_t expected;

  nn_core u_nn_core (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;               // 4 ns period
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("TIMEOUT: run did not finish within %0d cycles", watchdog_cycles);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  task automatic build_test(input int wmode, input int pmode);
    for (int i = 0; i < `INPUT_LEN; i++) begin
      case (pmode)
        pmode_ramp: pix_vals[i] = 16 * i + 10;
        pmode_full: pix_vals[i] = 255;
        default:    pix_vals[i] = lfsr_bits(8);
      endcase
      for (int n = 0; n < `NUM_NEURONS; n++) begin
        case (wmode)
          wmode_ident: hid_w[i][n] = (i == n) ? 16384 : 0;  // with the x2 gives gain 1
          wmode_sat:   hid_w[i][n] = (i == 0) ? sat_hidden[n] : 0;
          default:     hid_w[i][n] = rand_weight();
        endcase
      end
    end
    for (int k = 0; k < `NUM_NEURONS; k++) begin
      for (int n = 0; n < `NUM_NEURONS; n++) begin
        case (wmode)
          wmode_ident: out_w[k][n] = (k == n) ? 16384 :
                                     ((k == (n + 1) % `NUM_NEURONS) ? 8192 : 0);
          wmode_sat:   out_w[k][n] = sat_output[k][n];
          default:     out_w[k][n] = rand_weight();
        endcase
      end
    end
  endtask

  task automatic write_row(input layer_sel_t layer, input int addr, input vec_t row);
    @(posedge clk);
    w_we    <= 1'b1;
    w_layer <= layer;
    w_addr  <= addr_t'(addr);
    w_data  <= row;
  endtask

  task automatic load_weights();
    vec_t row;
    for (int i = 0; i < `INPUT_LEN; i++) begin
      for (int n = 0; n < `NUM_NEURONS; n++) begin
        row[n*`Q_W +: `Q_W] = q15_t'(hid_w[i][n]);
      end
      write_row(layer_hidden, i, row);
    end
    for (int k = 0; k < `NUM_NEURONS; k++) begin
      for (int n = 0; n < `NUM_NEURONS; n++) begin
        row[n*`Q_W +: `Q_W] = q15_t'(out_w[k][n]);
      end
      write_row(layer_output, k, row);
    end
    @(posedge clk);
    w_we <= 1'b0;
  endtask

  task automatic stream_image(input int gap);
    logic taken;
    for (int i = 0; i < `INPUT_LEN; i++) begin
      while (lfsr_bits(4) < gap) begin
        pixel_valid <= 1'b0;             // idle cycle
        @(posedge clk);
      end
      pixel_valid <= 1'b1;
      pixel       <= pix_t'(pix_vals[i]);
      do begin
        @(negedge clk);
        taken = pixel_ready;             // mid cycle sample
        @(posedge clk);
      end while (!taken);
    end
    pixel_valid <= 1'b0;
  endtask

  task automatic collect_result(input int stall, input vec_t want);
    int   edges;
    vec_t held;
    logic taken;
    edges = 0;
    @(negedge clk);
    while (!result_valid) begin          // edges since the last pixel
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    check(vec_t'(edges), vec_t'(`NUM_NEURONS + 2), "result_valid latency after last pixel");
    check(result, want, "result vector");
    held = result;
    do begin
      @(posedge clk);
      result_ready <= (lfsr_bits(4) >= stall);
      @(negedge clk);
      check(vec_t'(result_valid), vec_t'(1), "result_valid dropped before hand-off");
      check(result, held, "result changed while stalled");
      check(vec_t'(pixel_ready), vec_t'(0), "pixel_ready high with result pending");
      taken = result_ready;
    end while (!taken);
    @(posedge clk);                      // hand-off edge
    result_ready <= 1'b0;
    @(negedge clk);
    check(vec_t'(result_valid), vec_t'(0), "second result for one image");
    check(vec_t'(pixel_ready), vec_t'(1), "pixel_ready after hand-off");
  endtask

  initial begin
    reset        = 1'b1;
    pixel_valid  = 1'b0;
    pixel        = '0;
    w_we         = 1'b0;
    w_layer      = layer_hidden;
    w_addr       = '0;
    w_data       = '0;
    result_ready = 1'b0;
    repeat (16) begin
      @(negedge clk);
      check(vec_t'(pixel_ready), vec_t'(0), "pixel_ready during reset");
      check(vec_t'(result_valid), vec_t'(0), "result_valid during reset");
    end
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);                      // first edge out of reset still ahead
    check(vec_t'(pixel_ready), vec_t'(0), "pixel_ready before first edge after reset");
    check(vec_t'(result_valid), vec_t'(0), "result_valid after reset");
    @(posedge clk);
    @(negedge clk);
    check(vec_t'(pixel_ready), vec_t'(1), "pixel_ready once running");
    for (int t = 0; t < num_tests; t++) begin
      build_test(tests[t].wmode, tests[t].pmode);
      expected = (tests[t].wmode == wmode_random) ? ref_forward() : tests[t].expected;
      load_weights();
      stream_image(tests[t].gap);
      collect_result(tests[t].stall, expected);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* nn_core.f */
+incdir+src
+incdir+tests
src/nn_pkg.sv
src/weight_mem.sv
src/mac_slice.sv
src/neuron_array.sv
src/layer_controller.sv
src/nn_core.sv
tests/nn_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the nn_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f nn_core.f --top-module nn_core_tb -o nn_core_sim

# the log decides pass or fail
./obj_dir/nn_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
grep -q "Simulation completed successfully" sim.log
